// File: filelist.f
+incdir+test
verilog/isa_pkg.sv
verilog/issue_if.sv
verilog/result_if.sv
verilog/issue_stage.sv
verilog/exec_lane.sv
verilog/retire_unit.sv
verilog/issue_exec_top.sv
test/issue_tb.sv

// File: Makefile
TOP := issue_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard verilog/*.sv) $(wildcard test/*.sv test/*.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

// File: test/issue_ref.svh
// reference model of the issue slice: sequential execution and expected commit records
`ifndef ISSUE_REF_SVH
`define ISSUE_REF_SVH

// one retired instruction as seen on a commit port
typedef struct packed {
    logic [xlen-1:0] pc;
    reg_addr_t       rd;
    logic            we;
    logic [xlen-1:0] value;
    exc_t            exc;
} commit_rec_t;

// nop without exception is an empty slot and never commits
function automatic logic slot_empty(instr_t in);
    return in.op == op_nop && in.exc == '0;
endfunction

// value of one instruction executed on its own, a and b already read from the registers
function automatic logic [xlen-1:0] ref_result(instr_t in, logic [xlen-1:0] a,
                                               logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    r = '0;
    case (in.op)
        op_add:  r = a + b;
        op_sub:  r = a - b;
        op_and:  r = a & b;
        op_or:   r = a | b;
        op_xor:  r = a ^ b;
        op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_sltu: r = (a < b) ? 32'd1 : 32'd0;
        op_addi: r = a + in.imm;
        // shift amount is the low 5 bits of rk
        op_sll:  r = a << b[4:0];
        default: r = '0;
    endcase
    return r;
endfunction

// expected commit record; exceptions and writes to x0 leave the registers alone
function automatic commit_rec_t expected_commit(instr_t in, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
    commit_rec_t rec;
    rec.pc    = in.pc;
    rec.rd    = in.rd;
    rec.exc   = in.exc;
    rec.we    = in.exc == '0 && in.op != op_nop && in.rd != '0;
    rec.value = ref_result(in, a, b);
    return rec;
endfunction

`endif

// File: test/issue_tb.sv
// testbench for the issue and execute slice, random programs checked against a sequential model
`timescale 1ns/1ps

module issue_tb;
    import isa_pkg::*;

    `include "issue_ref.svh"

    // main stream, then an old program cut by a flush, then the new program
    localparam int prog_len        = 400;
    localparam int a_lo            = 300;
    localparam int b_lo            = 350;
    localparam int watchdog_cycles = prog_len * (max_shift + 6) + 2000;

    logic            clk;
    logic            rst;
    logic            flush;
    op_t             slot0_op;
    reg_addr_t       slot0_rd;
    reg_addr_t       slot0_rj;
    reg_addr_t       slot0_rk;
    logic [xlen-1:0] slot0_imm;
    logic [xlen-1:0] slot0_pc;
    exc_t            slot0_exc;
    op_t             slot1_op;
    reg_addr_t       slot1_rd;
    reg_addr_t       slot1_rj;
    reg_addr_t       slot1_rk;
    logic [xlen-1:0] slot1_imm;
    logic [xlen-1:0] slot1_pc;
    exc_t            slot1_exc;
    logic [1:0]      num_read;
    logic            commit0_valid;
    logic [xlen-1:0] commit0_pc;
    reg_addr_t       commit0_rd;
    logic            commit0_we;
    logic [xlen-1:0] commit0_value;
    exc_t            commit0_exc;
    logic            commit1_valid;
    logic [xlen-1:0] commit1_pc;
    reg_addr_t       commit1_rd;
    logic            commit1_we;
    logic [xlen-1:0] commit1_value;
    exc_t            commit1_exc;

    instr_t          prog [prog_len];
    logic [xlen-1:0] model_rf [32] = '{default: '0};
    int              cm_idx = 0;
    logic            flush_seen = 1'b0;

    issue_exec_top #(.num_lanes(2)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
            abort_run();
        end
    endtask

    // small register set so that pairs often depend on each other
    function automatic instr_t random_instr(logic [xlen-1:0] pc);
        instr_t in;
        int     kind;
        in      = '0;
        kind    = $urandom_range(0, 99);
        in.pc   = pc;
        in.rd   = 5'($urandom_range(0, 7));
        in.rj   = 5'($urandom_range(0, 7));
        in.rk   = 5'($urandom_range(0, 7));
        in.imm  = $urandom();
        if (kind < 10) begin
            in = '0;
        end else if (kind < 18) begin
            in.op  = op_t'(4'($urandom_range(0, 9)));
            in.exc = 7'($urandom_range(1, 127));
        end else if (kind < 32) begin
            in.op = op_sll;
        end else if (kind < 52) begin
            in.op = op_addi;
        end else begin
            in.op = op_t'(4'($urandom_range(1, 7)));
        end
        return in;
    endfunction

    function automatic int next_valid(int idx);
        int i;
        i = idx;
        while (i < prog_len && slot_empty(prog[i])) begin
            i++;
        end
        return i;
    endfunction

    function automatic int last_valid(int lo, int hi);
        int last;
        last = lo - 1;
        for (int i = lo; i < hi; i++) begin
            if (!slot_empty(prog[i])) begin
                last = i;
            end
        end
        return last;
    endfunction

    function automatic int slots_taken(logic [1:0] nr);
        case (nr)
            2'b11:   return 2;
            2'b01:   return 1;
            default: return 0;
        endcase
    endfunction

    // drives entries idx and idx+1, empty past the end of the segment
    task automatic present(input int idx, input int hi);
        instr_t s0;
        instr_t s1;
        s0 = '0;
        s1 = '0;
        if (idx < hi) begin
            s0 = prog[idx];
        end
        if (idx + 1 < hi) begin
            s1 = prog[idx + 1];
        end
        slot0_op  <= s0.op;
        slot0_rd  <= s0.rd;
        slot0_rj  <= s0.rj;
        slot0_rk  <= s0.rk;
        slot0_imm <= s0.imm;
        slot0_pc  <= s0.pc;
        slot0_exc <= s0.exc;
        slot1_op  <= s1.op;
        slot1_rd  <= s1.rd;
        slot1_rj  <= s1.rj;
        slot1_rk  <= s1.rk;
        slot1_imm <= s1.imm;
        slot1_pc  <= s1.pc;
        slot1_exc <= s1.exc;
    endtask

    // slots for lo are already on the inputs; advance by what num_read reports
    task automatic feed(input int lo, input int hi, input int max_cycles);
        int idx;
        int cycles;
        idx    = lo;
        cycles = 0;
        while (idx < hi && cycles < max_cycles) begin
            @(posedge clk);
            idx += slots_taken(num_read);
            present(idx, hi);
            cycles++;
        end
    endtask

    task automatic check_commit(input int port, input logic [xlen-1:0] pc, input reg_addr_t rd,
                                input logic we, input logic [xlen-1:0] value, input exc_t exc);
        commit_rec_t want;
        instr_t      in;
        string       p;
        p      = $sformatf("commit%0d", port);
        cm_idx = next_valid(cm_idx);
        // flushed tail of the old program never commits
        if (flush_seen && cm_idx < b_lo && pc != prog[cm_idx].pc) begin
            cm_idx = next_valid(b_lo);
        end
        if (cm_idx >= prog_len) begin
            $display("%s retired pc 0x%08h after the whole program had committed", p, pc);
            abort_run();
        end else begin
            in   = prog[cm_idx];
            want = expected_commit(in, model_rf[in.rj], model_rf[in.rk]);
            check({p, "_pc"}, pc, want.pc);
            check({p, "_exc"}, 32'(exc), 32'(want.exc));
            check({p, "_we"}, {31'd0, we}, {31'd0, want.we});
            if (want.exc == '0) begin
                check({p, "_rd"}, 32'(rd), 32'(want.rd));
                check({p, "_value"}, value, want.value);
            end
            if (want.we) begin
                model_rf[want.rd] = want.value;
            end
            cm_idx++;
        end
    endtask

    // commit0 is the older one when both are valid
    always @(posedge clk) begin
        if (!rst) begin
            if (commit1_valid) begin
                check("commit0_valid", {31'd0, commit0_valid}, 32'd1);
            end
            if (commit0_valid) begin
                check_commit(0, commit0_pc, commit0_rd, commit0_we, commit0_value, commit0_exc);
            end
            if (commit1_valid) begin
                check_commit(1, commit1_pc, commit1_rd, commit1_we, commit1_value, commit1_exc);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired, commit stream incomplete after %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        logic [xlen-1:0] pc;
        int              last1;
        int              last_b;
        void'($urandom(16570));
        rst   <= 1'b1;
        flush <= 1'b0;
        present(0, 0);
        for (int i = 0; i < prog_len; i++) begin
            if (i < a_lo) begin
                pc = 32'h1000 + 32'(4 * i);
            end else if (i < b_lo) begin
                pc = 32'h4000 + 32'(4 * (i - a_lo));
            end else begin
                pc = 32'h8000 + 32'(4 * (i - b_lo));
            end
            prog[i] = random_instr(pc);
        end
        last1  = last_valid(0, a_lo);
        last_b = last_valid(b_lo, prog_len);

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("num_read", 32'(num_read), 32'd3);

        // long random stream with empties, exceptions and slow shifts
        present(0, a_lo);
        feed(0, a_lo, watchdog_cycles);
        while (cm_idx <= last1) begin
            @(posedge clk);
        end

        // old program cut short, slots in the flush cycle are dropped
        @(posedge clk);
        present(a_lo, b_lo);
        feed(a_lo, b_lo, 30);
        @(posedge clk);
        flush      <= 1'b1;
        flush_seen = 1'b1;
        present(b_lo, prog_len);
        @(posedge clk);
        flush <= 1'b0;
        feed(b_lo, prog_len, watchdog_cycles);
        while (cm_idx <= last_b) begin
            @(posedge clk);
        end

        // any late commit past the end is caught here
        repeat (10) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/issue_exec_top.sv
// issue and execute slice top: issue stage, generated execute lanes and retire unit
`timescale 1ns/1ps

module issue_exec_top #(
    parameter int num_lanes = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  isa_pkg::op_t              slot0_op,
    input  isa_pkg::reg_addr_t        slot0_rd,
    input  isa_pkg::reg_addr_t        slot0_rj,
    input  isa_pkg::reg_addr_t        slot0_rk,
    input  logic [isa_pkg::xlen-1:0]  slot0_imm,
    input  logic [isa_pkg::xlen-1:0]  slot0_pc,
    input  isa_pkg::exc_t             slot0_exc,
    input  isa_pkg::op_t              slot1_op,
    input  isa_pkg::reg_addr_t        slot1_rd,
    input  isa_pkg::reg_addr_t        slot1_rj,
    input  isa_pkg::reg_addr_t        slot1_rk,
    input  logic [isa_pkg::xlen-1:0]  slot1_imm,
    input  logic [isa_pkg::xlen-1:0]  slot1_pc,
    input  isa_pkg::exc_t             slot1_exc,
    output logic [1:0]                num_read,
    output logic                      commit0_valid,
    output logic [isa_pkg::xlen-1:0]  commit0_pc,
    output isa_pkg::reg_addr_t        commit0_rd,
    output logic                      commit0_we,
    output logic [isa_pkg::xlen-1:0]  commit0_value,
    output isa_pkg::exc_t             commit0_exc,
    output logic                      commit1_valid,
    output logic [isa_pkg::xlen-1:0]  commit1_pc,
    output isa_pkg::reg_addr_t        commit1_rd,
    output logic                      commit1_we,
    output logic [isa_pkg::xlen-1:0]  commit1_value,
    output isa_pkg::exc_t             commit1_exc
);
    import isa_pkg::*;

    instr_t          slot0;
    instr_t          slot1;
    reg_addr_t       rf_addr0;
    reg_addr_t       rf_addr1;
    reg_addr_t       rf_addr2;
    reg_addr_t       rf_addr3;
    logic [xlen-1:0] rf_data0;
    logic [xlen-1:0] rf_data1;
    logic [xlen-1:0] rf_data2;
    logic [xlen-1:0] rf_data3;
    logic            all_idle;

    issue_if  iss [num_lanes] ();
    result_if res [num_lanes] ();

    assign slot0 = '{op: slot0_op, rd: slot0_rd, rj: slot0_rj, rk: slot0_rk,
                     imm: slot0_imm, pc: slot0_pc, exc: slot0_exc};
    assign slot1 = '{op: slot1_op, rd: slot1_rd, rj: slot1_rj, rk: slot1_rk,
                     imm: slot1_imm, pc: slot1_pc, exc: slot1_exc};

    issue_stage u_issue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .slot0    (slot0),
        .slot1    (slot1),
        .num_read (num_read),
        .rf_addr0 (rf_addr0),
        .rf_addr1 (rf_addr1),
        .rf_addr2 (rf_addr2),
        .rf_addr3 (rf_addr3),
        .rf_data0 (rf_data0),
        .rf_data1 (rf_data1),
        .rf_data2 (rf_data2),
        .rf_data3 (rf_data3),
        .all_idle (all_idle),
        .lane0    (iss[0]),
        .lane1    (iss[1])
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        exec_lane u_lane (
            .clk (clk),
            .rst (rst),
            .req (iss[i]),
            .res (res[i])
        );
    end

    retire_unit #(
        .num_lanes (num_lanes)
    ) u_retire (
        .clk           (clk),
        .rst           (rst),
        .lanes         (res),
        .rf_addr0      (rf_addr0),
        .rf_addr1      (rf_addr1),
        .rf_addr2      (rf_addr2),
        .rf_addr3      (rf_addr3),
        .rf_data0      (rf_data0),
        .rf_data1      (rf_data1),
        .rf_data2      (rf_data2),
        .rf_data3      (rf_data3),
        .all_idle      (all_idle),
        .commit0_valid (commit0_valid),
        .commit0_pc    (commit0_pc),
        .commit0_rd    (commit0_rd),
        .commit0_we    (commit0_we),
        .commit0_value (commit0_value),
        .commit0_exc   (commit0_exc),
        .commit1_valid (commit1_valid),
        .commit1_pc    (commit1_pc),
        .commit1_rd    (commit1_rd),
        .commit1_we    (commit1_we),
        .commit1_value (commit1_value),
        .commit1_exc   (commit1_exc)
    );

endmodule

// File: verilog/retire_unit.sv
// retire unit: register file, in-order commit of lane results and lane release
`timescale 1ns/1ps

module retire_unit #(
    parameter int num_lanes = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    result_if.retire                  lanes [num_lanes],
    input  isa_pkg::reg_addr_t        rf_addr0,
    input  isa_pkg::reg_addr_t        rf_addr1,
    input  isa_pkg::reg_addr_t        rf_addr2,
    input  isa_pkg::reg_addr_t        rf_addr3,
    output logic [isa_pkg::xlen-1:0]  rf_data0,
    output logic [isa_pkg::xlen-1:0]  rf_data1,
    output logic [isa_pkg::xlen-1:0]  rf_data2,
    output logic [isa_pkg::xlen-1:0]  rf_data3,
    output logic                      all_idle,
    output logic                      commit0_valid,
    output logic [isa_pkg::xlen-1:0]  commit0_pc,
    output isa_pkg::reg_addr_t        commit0_rd,
    output logic                      commit0_we,
    output logic [isa_pkg::xlen-1:0]  commit0_value,
    output isa_pkg::exc_t             commit0_exc,
    output logic                      commit1_valid,
    output logic [isa_pkg::xlen-1:0]  commit1_pc,
    output isa_pkg::reg_addr_t        commit1_rd,
    output logic                      commit1_we,
    output logic [isa_pkg::xlen-1:0]  commit1_value,
    output isa_pkg::exc_t             commit1_exc
);
    import isa_pkg::*;

    logic [xlen-1:0]      rf [32];
    logic [num_lanes-1:0] busy;
    logic [num_lanes-1:0] done;
    logic [num_lanes-1:0] we;
    logic [num_lanes-1:0] release_q;
    reg_addr_t            rd [num_lanes];
    logic [xlen-1:0]      value [num_lanes];
    logic [xlen-1:0]      pc [num_lanes];
    exc_t                 exc [num_lanes];
    logic                 retire;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign busy[i]  = lanes[i].busy;
        assign done[i]  = lanes[i].done;
        assign we[i]    = lanes[i].we && lanes[i].rd != '0;
        assign rd[i]    = lanes[i].rd;
        assign value[i] = lanes[i].value;
        assign pc[i]    = lanes[i].pc;
        assign exc[i]   = lanes[i].exc;
        assign lanes[i].release_lane = release_q[i];
    end

    assign all_idle = busy == '0;

    // group complete, but not again while the release is still being seen
    assign retire = !all_idle && (busy & ~done) == '0 && release_q == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            release_q <= '0;
        end else begin
            release_q <= retire ? busy : '0;
        end
    end

    // architectural registers start at zero, x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                rf[r] <= '0;
            end
        end else if (retire) begin
            // lane order, younger lane wins on equal rd
            for (int i = 0; i < num_lanes; i++) begin
                if (busy[i] && we[i]) begin
                    rf[rd[i]] <= value[i];
                end
            end
        end
    end

    assign rf_data0 = rf[rf_addr0];
    assign rf_data1 = rf[rf_addr1];
    assign rf_data2 = rf[rf_addr2];
    assign rf_data3 = rf[rf_addr3];

    always_ff @(posedge clk) begin
        if (rst) begin
            commit0_valid <= 1'b0;
            commit1_valid <= 1'b0;
        end else begin
            commit0_valid <= retire && busy[0];
            commit1_valid <= retire && busy[1];
        end
    end

    // lane 0 holds the older instruction of a pair
    always_ff @(posedge clk) begin
        if (retire) begin
            commit0_pc    <= pc[0];
            commit0_rd    <= rd[0];
            commit0_we    <= we[0];
            commit0_value <= value[0];
            commit0_exc   <= exc[0];
            commit1_pc    <= pc[1];
            commit1_rd    <= rd[1];
            commit1_we    <= we[1];
            commit1_value <= value[1];
            commit1_exc   <= exc[1];
        end
    end

    a_release_done: assert property (@(posedge clk) disable iff (rst)
        (release_q & ~done) == '0);

endmodule

// File: verilog/exec_lane.sv
// execute lane: single-cycle ALU and an iterative shift-left, result held until retired
`timescale 1ns/1ps

module exec_lane (
    input  logic   clk,
    input  logic   rst,
    issue_if.lane  req,
    result_if.lane res
);
    import isa_pkg::*;

    logic            busy;
    logic            done;
    logic            finish;
    op_t             op;
    reg_addr_t       rd;
    exc_t            exc;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] acc;
    logic [xlen-1:0] opnd_b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] result;
    logic [xlen-1:0] alu_out;
    logic [4:0]      step;
    logic [5:0]      done_age;

    assign req.ready = !busy;

    // sll runs until the step count meets the shift amount
    assign finish = op != op_sll || exc != '0 || step == opnd_b[4:0];

    always_comb begin
        case (op)
            op_add:  alu_out = acc + opnd_b;
            op_sub:  alu_out = acc - opnd_b;
            op_and:  alu_out = acc & opnd_b;
            op_or:   alu_out = acc | opnd_b;
            op_xor:  alu_out = acc ^ opnd_b;
            op_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(acc) < $signed(opnd_b)};
            op_sltu: alu_out = {{(xlen-1){1'b0}}, acc < opnd_b};
            op_addi: alu_out = acc + imm;
            // shifting already happened in acc
            op_sll:  alu_out = acc;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else if (done && res.release_lane) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (req.en && !busy) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy && !done) begin
            if (finish) begin
                done <= 1'b1;
            end else begin
                step <= step + 5'd1;
            end
        end
    end

    // instruction and operand capture, then shift or result
    always_ff @(posedge clk) begin
        if (req.en && !busy) begin
            op     <= req.instr.op;
            rd     <= req.instr.rd;
            exc    <= req.instr.exc;
            pc     <= req.instr.pc;
            imm    <= req.instr.imm;
            acc    <= req.src_a;
            opnd_b <= req.src_b;
        end else if (busy && !done) begin
            if (finish) begin
                result <= alu_out;
            end else begin
                acc <= acc << 1;
            end
        end
    end

    assign res.busy  = busy;
    assign res.done  = done;
    assign res.rd    = rd;
    assign res.we    = exc == '0 && op != op_nop;
    assign res.value = result;
    assign res.pc    = pc;
    assign res.exc   = exc;

    // cycles spent waiting in done for the retire unit
    always_ff @(posedge clk) begin
        if (rst || !done || res.release_lane) begin
            done_age <= '0;
        end else begin
            done_age <= done_age + 6'd1;
        end
    end

    // the other lane can still be shifting for up to max_shift steps
    a_done_bounded: assert property (@(posedge clk) disable iff (rst)
        done_age <= 6'(max_shift + 2));

endmodule

// File: verilog/issue_stage.sv
// issue stage that queues two instructions in order and pairs them onto two lanes
`timescale 1ns/1ps

module issue_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  isa_pkg::instr_t           slot0,
    input  isa_pkg::instr_t           slot1,
    output logic [1:0]                num_read,
    output isa_pkg::reg_addr_t        rf_addr0,
    output isa_pkg::reg_addr_t        rf_addr1,
    output isa_pkg::reg_addr_t        rf_addr2,
    output isa_pkg::reg_addr_t        rf_addr3,
    input  logic [isa_pkg::xlen-1:0]  rf_data0,
    input  logic [isa_pkg::xlen-1:0]  rf_data1,
    input  logic [isa_pkg::xlen-1:0]  rf_data2,
    input  logic [isa_pkg::xlen-1:0]  rf_data3,
    input  logic                      all_idle,
    issue_if.issue                    lane0,
    issue_if.issue                    lane1
);
    import isa_pkg::*;

    instr_t     q0;
    instr_t     q1;
    instr_t     in_a;
    logic [1:0] count;
    logic [1:0] n_out;
    logic [1:0] after_out;
    logic [1:0] n_in;
    logic       slot0_valid;
    logic       slot1_valid;
    logic       take0;
    logic       take1;
    logic       fire0;
    logic       fire1;
    logic       pair_hazard;

    // empty slot is a nop without exception
    assign slot0_valid = slot0.op != op_nop || slot0.exc != '0;
    assign slot1_valid = slot1.op != op_nop || slot1.exc != '0;

    // operand reads for both queue entries
    assign rf_addr0 = q0.rj;
    assign rf_addr1 = q0.rk;
    assign rf_addr2 = q1.rj;
    assign rf_addr3 = q1.rk;

    // younger entry reads the head's destination
    assign pair_hazard = q0.rd != '0 && (q1.rj == q0.rd || q1.rk == q0.rd);

    // new work only once the previous group has fully retired
    assign fire0 = all_idle && lane0.ready && count != 2'd0;
    assign fire1 = fire0 && lane1.ready && count == 2'd2
                   && q0.exc == '0 && q1.exc == '0 && !pair_hazard;

    assign lane0.en    = fire0;
    assign lane0.instr = q0;
    assign lane0.src_a = rf_data0;
    assign lane0.src_b = rf_data1;

    assign lane1.en    = fire1;
    assign lane1.instr = q1;
    assign lane1.src_a = rf_data2;
    assign lane1.src_b = rf_data3;

    // occupancy after this cycle's issue decides how many slots fit
    assign n_out     = {1'b0, fire0} + {1'b0, fire1};
    assign after_out = count - n_out;

    always_comb begin
        case (after_out)
            2'd2:    num_read = 2'b00;
            2'd1:    num_read = 2'b01;
            default: num_read = 2'b11;
        endcase
    end

    // with a single free entry only slot 0 is consumed even when empty
    assign take0 = num_read[0] && slot0_valid;
    assign take1 = num_read[1] && slot1_valid;
    assign n_in  = {1'b0, take0} + {1'b0, take1};

    // slot 1 moves up when slot 0 is empty
    assign in_a = take0 ? slot0 : slot1;

    // slots presented in a flush cycle are dropped with the queue
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= 2'd0;
        end else begin
            count <= after_out + n_in;
        end
    end

    always_ff @(posedge clk) begin
        case (after_out)
            2'd0: begin
                q0 <= in_a;
                q1 <= slot1;
            end
            2'd1: begin
                // surviving entry moves to the head
                if (n_out != 2'd0) begin
                    q0 <= q1;
                end
                q1 <= in_a;
            end
            default: begin
                q0 <= q0;
                q1 <= q1;
            end
        endcase
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst) count <= 2'd2);

    // lane 1 only holds work while lane 0 holds the older half of its pair
    a_lane1_pair: assert property (@(posedge clk) disable iff (rst)
        !lane1.ready |-> !lane0.ready);

endmodule

// File: verilog/result_if.sv
// result interface: lane status and finished result toward the retire unit
`timescale 1ns/1ps

interface result_if;
    import isa_pkg::*;

    logic            busy;
    logic            done;
    reg_addr_t       rd;
    logic            we;
    logic [xlen-1:0] value;
    logic [xlen-1:0] pc;
    exc_t            exc;
    // one-cycle pulse from retire, lane goes idle afterwards
    logic            release_lane;

    modport lane (
        output busy, done, rd, we, value, pc, exc,
        input  release_lane
    );

    modport retire (
        input  busy, done, rd, we, value, pc, exc,
        output release_lane
    );

endinterface

// File: verilog/issue_if.sv
// issue interface: one issued instruction with its operand values, issue stage to lane
`timescale 1ns/1ps

interface issue_if;
    import isa_pkg::*;

    logic            en;
    instr_t          instr;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic            ready;

    // issue stage side
    modport issue (
        output en, instr, src_a, src_b,
        input  ready
    );

    // execute lane side
    modport lane (
        input  en, instr, src_a, src_b,
        output ready
    );

endinterface

// File: verilog/isa_pkg.sv
// isa package: opcodes, decoded instruction layout and core widths

package isa_pkg;

    // data and pc width
    localparam int xlen = 32;

    // largest number of shift steps, bounds the sll latency
    localparam int max_shift = 31;

    // register index
    typedef logic [4:0] reg_addr_t;

    // exception code, zero means none
    typedef logic [6:0] exc_t;

    // nop with no exception marks an empty slot
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_slt  = 4'd6,
        op_sltu = 4'd7,
        op_addi = 4'd8,
        op_sll  = 4'd9
    } op_t;

    // decoded instruction as handed over by the decoder
    typedef struct packed {
        op_t             op;
        reg_addr_t       rd;
        reg_addr_t       rj;
        reg_addr_t       rk;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        exc_t            exc;
    } instr_t;

endpackage
